//--- rtl/te_defs.svh
// ####################
// trace connector widths shared by RTL and testbench
// ####################

`ifndef TE_DEFS_SVH
`define TE_DEFS_SVH

// retire slots per cycle
`define NRET 2

// address and trap value width
`define XLEN 32

// trace field widths
`define CAUSE_LEN 5
`define PRIV_LEN 2
`define ITYPE_LEN 3
`define IRETIRE_LEN 2

`endif

//--- rtl/te_pkg.sv
// ####################
// trace connector types: commit, branch, exception and trace slot records
// ####################

`include "te_defs.svh"

package te_pkg;

    // opcode class of a committed instruction
    typedef enum logic [1:0] {
        OP_OTHER  = 2'd0,
        OP_BRANCH = 2'd1,
        OP_JALR   = 2'd2,
        OP_XRET   = 2'd3
    } commit_op_e;

    // instruction type as seen by the trace encoder
    typedef enum logic [`ITYPE_LEN-1:0] {
        IT_STD   = 3'd0,
        IT_EXC   = 3'd1,
        IT_INT   = 3'd2,
        IT_XRET  = 3'd3,
        IT_NT_BR = 3'd4,
        IT_T_BR  = 3'd5,
        IT_UNINF = 3'd6
    } itype_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        commit_op_e       op;
        logic             is_compressed;
    } commit_entry_t;

    // resolved branch from the execute stage
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic             taken;
    } branch_res_t;

    typedef struct packed {
        logic                       valid;
        logic [$clog2(`NRET)-1:0]   slot;
        logic [`CAUSE_LEN-1:0]      cause;
        logic [`XLEN-1:0]           tval;
    } exception_t;

    // per-slot fields towards the encoder
    typedef struct packed {
        logic                     valid;
        itype_e                   itype;
        logic [`IRETIRE_LEN-1:0]  iretire;
        logic                     ilastsize;
        logic [`XLEN-1:0]         iaddr;
    } trace_slot_t;

endpackage

//--- rtl/te_slot_classifier.sv
// ####################
// one retire slot: classifies the instruction and registers its trace fields
// ####################

`include "te_defs.svh"

module te_slot_classifier (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 valid_i,
    input  te_pkg::commit_entry_t commit_i,
    input  te_pkg::branch_res_t  branch_i,
    input  logic                 interrupt_i,
    input  logic                 trap_i,
    input  logic                 flush_i,
    output te_pkg::trace_slot_t  slot_o
);

    te_pkg::trace_slot_t slot_d;
    logic                br_taken;

    // resolved branch belongs to this slot and was taken
    assign br_taken = branch_i.valid &&
                      (branch_i.pc == commit_i.pc) &&
                      branch_i.taken;

    always_comb begin
        slot_d = '0;
        if (!flush_i && trap_i) begin
            // trapping instruction retires nothing
            slot_d.valid     = 1'b1;
            slot_d.iaddr     = commit_i.pc;
            slot_d.iretire   = '0;
            slot_d.ilastsize = 1'b0;
            if (interrupt_i) begin
                slot_d.itype = te_pkg::IT_INT;
            end else begin
                slot_d.itype = te_pkg::IT_EXC;
            end
        end else if (!flush_i && valid_i) begin
            slot_d.valid = 1'b1;
            slot_d.iaddr = commit_i.pc;
            case (commit_i.op)
                te_pkg::OP_BRANCH: begin
                    if (br_taken) begin
                        slot_d.itype = te_pkg::IT_T_BR;
                    end else begin
                        slot_d.itype = te_pkg::IT_NT_BR;
                    end
                end
                te_pkg::OP_JALR: begin
                    slot_d.itype = te_pkg::IT_UNINF;
                end
                te_pkg::OP_XRET: begin
                    slot_d.itype = te_pkg::IT_XRET;
                end
                default: begin
                    slot_d.itype = te_pkg::IT_STD;
                end
            endcase
            // size in halfwords
            if (commit_i.is_compressed) begin
                slot_d.iretire   = `IRETIRE_LEN'(1);
                slot_d.ilastsize = 1'b0;
            end else begin
                slot_d.iretire   = `IRETIRE_LEN'(2);
                slot_d.ilastsize = 1'b1;
            end
        end
    end

    // output register, one cycle latency
    always_ff @(posedge clk) begin
        if (reset_i) begin
            slot_o <= '0;
        end else begin
            slot_o <= slot_d;
        end
    end

endmodule

//--- rtl/te_trap_tracker.sv
// ####################
// trap decode per slot, holds last cause/tval and current privilege
// ####################

`include "te_defs.svh"

module te_trap_tracker (
    input  logic                   clk,
    input  logic                   reset_i,
    input  te_pkg::exception_t     exception_i,
    input  logic [`PRIV_LEN-1:0]   priv_lvl_i,
    output logic [`NRET-1:0]       trap_vec_o,
    output logic [`NRET-1:0]       flush_vec_o,
    output logic [`CAUSE_LEN-1:0]  cause_o,
    output logic [`XLEN-1:0]       tval_o,
    output logic [`PRIV_LEN-1:0]   priv_o
);

    localparam logic [`PRIV_LEN-1:0] PRIV_MACHINE = 2'b11;

    // trapping slot and the younger ones behind it
    always_comb begin
        trap_vec_o  = '0;
        flush_vec_o = '0;
        if (exception_i.valid) begin
            for (int k = 0; k < `NRET; k++) begin
                if (k == int'(exception_i.slot)) begin
                    trap_vec_o[k] = 1'b1;
                end else if (k > int'(exception_i.slot)) begin
                    flush_vec_o[k] = 1'b1;
                end
            end
        end
    end

    // last trap info stays until the next trap
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cause_o <= '0;
            tval_o  <= '0;
        end else if (exception_i.valid) begin
            cause_o <= exception_i.cause;
            tval_o  <= exception_i.tval;
        end
    end

    // privilege follows the core every cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            priv_o <= PRIV_MACHINE;
        end else begin
            priv_o <= priv_lvl_i;
        end
    end

endmodule

//--- rtl/te_connector.sv
// ####################
// trace ingress connector: dual-retire commit to encoder trace fields
// ####################

`include "te_defs.svh"

module te_connector (
    input  logic                                clk,
    input  logic                                reset_i,

    // commit side of the core
    input  logic [`NRET-1:0]                    valid_i,
    input  te_pkg::commit_entry_t [`NRET-1:0]   commit_i,
    input  te_pkg::branch_res_t                 branch_i,
    input  te_pkg::exception_t                  exception_i,
    input  logic                                interrupt_i,
    input  logic [`PRIV_LEN-1:0]                priv_lvl_i,

    // towards the trace encoder
    output te_pkg::trace_slot_t [`NRET-1:0]     slot_o,
    output logic [`CAUSE_LEN-1:0]               cause_o,
    output logic [`XLEN-1:0]                    tval_o,
    output logic [`PRIV_LEN-1:0]                priv_o
);

    // per-slot trap and squash flags
    logic [`NRET-1:0] trap_vec;
    logic [`NRET-1:0] flush_vec;

    te_trap_tracker u_trap_tracker (
        .clk         (clk),
        .reset_i     (reset_i),
        .exception_i (exception_i),
        .priv_lvl_i  (priv_lvl_i),
        .trap_vec_o  (trap_vec),
        .flush_vec_o (flush_vec),
        .cause_o     (cause_o),
        .tval_o      (tval_o),
        .priv_o      (priv_o)
    );

    // one classifier per retire slot
    for (genvar k = 0; k < `NRET; k++) begin : g_slot
        te_slot_classifier u_slot_classifier (
            .clk         (clk),
            .reset_i     (reset_i),
            .valid_i     (valid_i[k]),
            .commit_i    (commit_i[k]),
            .branch_i    (branch_i),
            .interrupt_i (interrupt_i),
            .trap_i      (trap_vec[k]),
            .flush_i     (flush_vec[k]),
            .slot_o      (slot_o[k])
        );
    end

endmodule

//--- dv/te_checker.sv
// ####################
// trace connector checker: reference model of slots, trap info and privilege
// ####################

`include "te_defs.svh"

module te_checker (
    input  logic                               clk,
    input  logic                               reset_i,
    input  logic [`NRET-1:0]                   valid_i,
    input  te_pkg::commit_entry_t [`NRET-1:0]  commit_i,
    input  te_pkg::branch_res_t                branch_i,
    input  te_pkg::exception_t                 exception_i,
    input  logic                               interrupt_i,
    input  logic [`PRIV_LEN-1:0]               priv_lvl_i,
    input  te_pkg::trace_slot_t [`NRET-1:0]    slot_i,
    input  logic [`CAUSE_LEN-1:0]              cause_i,
    input  logic [`XLEN-1:0]                   tval_i,
    input  logic [`PRIV_LEN-1:0]               priv_i,
    output int                                 error_count_o,
    output int                                 check_count_o
);

    typedef te_pkg::trace_slot_t [`NRET-1:0] slot_vec_t;

    slot_vec_t             exp_slots;
    logic [`CAUSE_LEN-1:0] exp_cause;
    logic [`XLEN-1:0]      exp_tval;
    logic [`PRIV_LEN-1:0]  exp_priv;
    bit                    have_exp = 1'b0;
    int                    errors = 0;
    int                    checks = 0;

    assign error_count_o = errors;
    assign check_count_o = checks;

    // expected trace fields for one commit group
    function automatic slot_vec_t expected_slots(
        input logic [`NRET-1:0]                  valid,
        input te_pkg::commit_entry_t [`NRET-1:0] commit,
        input te_pkg::branch_res_t               branch,
        input te_pkg::exception_t                exc,
        input logic                              intr
    );
        slot_vec_t res;
        res = '0;
        for (int k = 0; k < `NRET; k++) begin
            if (exc.valid && k > int'(exc.slot)) begin
                // younger than the trap, squashed
                res[k] = '0;
            end else if (exc.valid && k == int'(exc.slot)) begin
                res[k].valid = 1'b1;
                res[k].itype = intr ? te_pkg::IT_INT : te_pkg::IT_EXC;
                res[k].iaddr = commit[k].pc;
            end else if (valid[k]) begin
                res[k].valid     = 1'b1;
                res[k].iaddr     = commit[k].pc;
                res[k].iretire   = commit[k].is_compressed ? 2'd1 : 2'd2;
                res[k].ilastsize = !commit[k].is_compressed;
                unique case (commit[k].op)
                    te_pkg::OP_OTHER:  res[k].itype = te_pkg::IT_STD;
                    te_pkg::OP_JALR:   res[k].itype = te_pkg::IT_UNINF;
                    te_pkg::OP_XRET:   res[k].itype = te_pkg::IT_XRET;
                    default: begin
                        if (branch.valid && branch.taken && branch.pc == commit[k].pc) begin
                            res[k].itype = te_pkg::IT_T_BR;
                        end else begin
                            res[k].itype = te_pkg::IT_NT_BR;
                        end
                    end
                endcase
            end
        end
        return res;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("FAIL t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp_v, act_v);
        end
    endtask

    // inputs are stable at the edge, so the model steps here
    always @(posedge clk) begin
        have_exp = 1'b1;
        if (reset_i) begin
            exp_slots = '0;
            exp_cause = '0;
            exp_tval  = '0;
            exp_priv  = 2'b11;
        end else begin
            exp_slots = expected_slots(valid_i, commit_i, branch_i, exception_i, interrupt_i);
            if (exception_i.valid) begin
                exp_cause = exception_i.cause;
                exp_tval  = exception_i.tval;
            end
            exp_priv = priv_lvl_i;
        end
    end

    // registered outputs have settled by the falling edge
    always @(negedge clk) begin
        if (have_exp) begin
            for (int k = 0; k < `NRET; k++) begin
                compare_value($sformatf("slot_o[%0d]", k), 64'(exp_slots[k]), 64'(slot_i[k]));
            end
            compare_value("cause_o", 64'(exp_cause), 64'(cause_i));
            compare_value("tval_o", 64'(exp_tval), 64'(tval_i));
            compare_value("priv_o", 64'(exp_priv), 64'(priv_i));
        end
    end

endmodule

//--- dv/tb_te_connector.sv
// ####################
// trace connector testbench driving LFSR stimulus over six phases
// ####################

`include "te_defs.svh"

module tb_te_connector;

    localparam int RESET_LEN  = 5;
    localparam int STD_LEN    = 40;
    localparam int BRANCH_LEN = 40;
    localparam int TRAP_LEN   = 40;
    localparam int JUMP_LEN   = 24;
    localparam int PRIV_LEN_C = 48;
    localparam int TIMEOUT_CYCLES =
        RESET_LEN + STD_LEN + BRANCH_LEN + TRAP_LEN + JUMP_LEN + PRIV_LEN_C + 50;

    logic                               clk;
    logic                               reset;
    logic [`NRET-1:0]                   valid;
    te_pkg::commit_entry_t [`NRET-1:0]  commit;
    te_pkg::branch_res_t                branch;
    te_pkg::exception_t                 exception;
    logic                               interrupt;
    logic [`PRIV_LEN-1:0]               priv_lvl;
    te_pkg::trace_slot_t [`NRET-1:0]    slot;
    logic [`CAUSE_LEN-1:0]              cause;
    logic [`XLEN-1:0]                   tval;
    logic [`PRIV_LEN-1:0]               priv;
    int                                 error_count;
    int                                 check_count;
    int                                 cycle_count = 0;
    logic [31:0]                        lfsr_state = 32'h840a_e7dd;

    te_connector dut_i (
        .clk(clk), .reset_i(reset), .valid_i(valid), .commit_i(commit),
        .branch_i(branch), .exception_i(exception), .interrupt_i(interrupt),
        .priv_lvl_i(priv_lvl), .slot_o(slot), .cause_o(cause), .tval_o(tval),
        .priv_o(priv)
    );

    te_checker checker_i (
        .clk(clk), .reset_i(reset), .valid_i(valid), .commit_i(commit),
        .branch_i(branch), .exception_i(exception), .interrupt_i(interrupt),
        .priv_lvl_i(priv_lvl), .slot_i(slot), .cause_i(cause), .tval_i(tval),
        .priv_i(priv), .error_count_o(error_count), .check_count_o(check_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic drive_idle();
        valid     = '0;
        commit    = '0;
        branch    = '0;
        exception = '0;
        interrupt = 1'b0;
        priv_lvl  = 2'b11;
    endtask

    // one random commit group shaped for the given phase
    task automatic drive_group(input int phase);
        logic [1:0] op_bits;
        logic [1:0] pick;
        for (int k = 0; k < `NRET; k++) begin
            commit[k].pc = `XLEN'(draw_bits(31) << 1);
            commit[k].is_compressed = 1'(draw_bits(1));
            op_bits = 2'(draw_bits(2));
            case (phase)
                2: commit[k].op = te_pkg::OP_OTHER;
                3: commit[k].op = op_bits[0] ? te_pkg::OP_BRANCH : te_pkg::OP_OTHER;
                5: commit[k].op = (op_bits == 2'd1) ? te_pkg::OP_JALR
                                                    : te_pkg::commit_op_e'(op_bits);
                default: commit[k].op = te_pkg::commit_op_e'(op_bits);
            endcase
        end
        valid = `NRET'(draw_bits(`NRET));
        // branch record points at slot 0, slot 1 or somewhere else
        pick = 2'(draw_bits(2));
        branch.valid = (phase == 3 || phase == 4 || phase == 6) && (2'(draw_bits(2)) != 2'd0);
        branch.taken = 1'(draw_bits(1));
        case (pick)
            2'd1:    branch.pc = commit[1].pc;
            2'd3:    branch.pc = draw_bits(`XLEN);
            default: branch.pc = commit[0].pc;
        endcase
        exception.valid = (phase == 4 || phase == 6) && (1'(draw_bits(1)) == 1'b1);
        exception.slot  = 1'(draw_bits(1));
        exception.cause = `CAUSE_LEN'(draw_bits(`CAUSE_LEN));
        exception.tval  = draw_bits(`XLEN);
        interrupt = (phase == 4 || phase == 6) && (1'(draw_bits(1)) == 1'b1);
        priv_lvl  = (phase == 6) ? `PRIV_LEN'(draw_bits(`PRIV_LEN)) : 2'b11;
    endtask

    task automatic report_phase(input string name, input int err_start, input int chk_start);
        // let the last group of the phase reach the checker
        @(posedge clk);
        @(negedge clk);
        // checker counts settle just after its compare
        #1;
        $display("phase %s: %s, %0d checks, %0d errors", name,
                 (error_count == err_start) ? "ok" : "mismatches",
                 check_count - chk_start, error_count - err_start);
    endtask

    task automatic run_phase(input int phase, input int len, input string name);
        int e0;
        int c0;
        e0 = error_count;
        c0 = check_count;
        repeat (len) begin
            @(posedge clk);
            #1;
            drive_group(phase);
        end
        report_phase(name, e0, c0);
    endtask

    initial begin
        drive_idle();
        reset = 1'b1;
        // random inputs while reset is held must not leak out
        for (int i = 0; i < RESET_LEN; i++) begin
            @(posedge clk);
            #1;
            if (i < 2) begin
                drive_group(6);
            end else begin
                reset = 1'b0;
                drive_idle();
            end
        end
        report_phase("1 reset state", 0, 0);
        run_phase(2, STD_LEN, "2 standard retirement");
        run_phase(3, BRANCH_LEN, "3 branches");
        run_phase(4, TRAP_LEN, "4 traps");
        run_phase(5, JUMP_LEN, "5 jumps and returns");
        run_phase(6, PRIV_LEN_C, "6 privilege");
        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+rtl
rtl/te_pkg.sv
rtl/te_slot_classifier.sv
rtl/te_trap_tracker.sv
rtl/te_connector.sv
dv/te_checker.sv
dv/tb_te_connector.sv

//--- run.sh
#!/bin/sh
# compile and run the trace connector testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_te_connector \
    -Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
